//--- rtl/uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// ==========================================================================
// serial line timing
// ==========================================================================

// clock cycles per serial bit
`define UART_CLKS_PER_BIT 16

// data bits per frame, sent lsb first
`define UART_DATA_BITS 8

// ==========================================================================
// byte buffer and button
// ==========================================================================

// bytes held for replay
`define UART_BUF_DEPTH 32

// cycles a new button level must hold before it counts
`define DEBOUNCE_CYCLES 8

`endif

//--- rtl/uart_pkg.sv
`default_nettype none

`include "uart_consts.svh"

package uart_pkg;

    // one serial data byte
    typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

    // index into the byte buffer
    typedef logic [$clog2(`UART_BUF_DEPTH)-1:0] buf_addr_t;

    // fill count, 0 up to full depth inclusive
    typedef logic [$clog2(`UART_BUF_DEPTH+1)-1:0] buf_len_t;

    // single-cycle byte strobe, no back-pressure
    typedef struct packed {
        logic       valid;
        uart_byte_t data;
    } byte_strobe_t;

endpackage

`default_nettype wire

//--- rtl/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_consts.svh"

module uart_rx (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rxd,
    output uart_pkg::byte_strobe_t rx_byte
);

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
    localparam int BIT_W = $clog2(`UART_DATA_BITS);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`UART_CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);
    localparam logic [BIT_W-1:0] DATA_LAST = BIT_W'(`UART_DATA_BITS - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t              state;
    logic                   rx_meta;
    logic                   rx_sync;
    logic [CNT_W-1:0]       cnt;
    logic [BIT_W-1:0]       bit_idx;
    logic                   valid_q;
    uart_pkg::uart_byte_t   shreg;

    // ======================================================================
    // input synchronizer, line idles high
    // ======================================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rxd;
            rx_sync <= rx_meta;
        end
    end

    // ======================================================================
    // frame FSM
    // ======================================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    // falling edge opens a frame
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // half a bit to reach mid start bit
                    if (cnt == HALF_LAST) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // line back high means a glitch
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == BIT_LAST) begin
                        cnt <= '0;
                        if (bit_idx == DATA_LAST) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (cnt == BIT_LAST) begin
                        cnt     <= '0;
                        state   <= RX_IDLE;
                        // framing error drops the byte
                        valid_q <= rx_sync;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // data bits arrive lsb first, shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && cnt == BIT_LAST) begin
            shreg <= {rx_sync, shreg[`UART_DATA_BITS-1:1]};
        end
    end

    assign rx_byte = '{valid: valid_q, data: shreg};

    // one frame takes many cycles, so strobes can never touch
    a_strobe_single : assert property (
        @(posedge clk) disable iff (reset) rx_byte.valid |=> !rx_byte.valid
    );

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_consts.svh"

module uart_tx (
    input  logic                   clk,
    input  logic                   reset,
    input  uart_pkg::byte_strobe_t tx_req,
    output logic                   txd,
    output logic                   tx_done,
    output logic                   busy
);

    // start + data + stop
    localparam int FRAME_BITS = `UART_DATA_BITS + 2;
    localparam int CNT_W      = $clog2(`UART_CLKS_PER_BIT);
    localparam int IDX_W      = $clog2(FRAME_BITS);
    localparam logic [CNT_W-1:0] BIT_LAST   = CNT_W'(`UART_CLKS_PER_BIT - 1);
    localparam logic [IDX_W-1:0] FRAME_LAST = IDX_W'(FRAME_BITS - 1);

    logic [FRAME_BITS-1:0] shreg;
    logic [CNT_W-1:0]      cnt;
    logic [IDX_W-1:0]      bit_idx;

    // ======================================================================
    // frame shifter
    // ======================================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // all ones keeps the line idle high
            shreg   <= '1;
            cnt     <= '0;
            bit_idx <= '0;
            busy    <= 1'b0;
            tx_done <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            if (!busy) begin
                if (tx_req.valid) begin
                    // stop, data, start; bit 0 goes out first
                    shreg   <= {1'b1, tx_req.data, 1'b0};
                    cnt     <= '0;
                    bit_idx <= '0;
                    busy    <= 1'b1;
                end
            end else if (cnt == BIT_LAST) begin
                cnt   <= '0;
                shreg <= {1'b1, shreg[FRAME_BITS-1:1]};
                // end of stop bit
                if (bit_idx == FRAME_LAST) begin
                    busy    <= 1'b0;
                    tx_done <= 1'b1;
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign txd = shreg[0];

    // sequencer must wait for tx_done before the next byte
    a_no_req_busy : assert property (
        @(posedge clk) disable iff (reset) tx_req.valid |-> !busy
    );

endmodule

`default_nettype wire

//--- rtl/button_debounce.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_consts.svh"

module button_debounce (
    input  logic clk,
    input  logic reset,
    input  logic btn,
    output logic pulse
);

    localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`DEBOUNCE_CYCLES - 1);

    logic             btn_meta;
    logic             btn_sync;
    logic             level;
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
            level    <= 1'b0;
            cnt      <= '0;
            pulse    <= 1'b0;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
            pulse    <= 1'b0;
            if (btn_sync != level) begin
                // held long enough, take the new level
                if (cnt == CNT_LAST) begin
                    cnt   <= '0;
                    level <= btn_sync;
                    // press only, release is silent
                    pulse <= btn_sync;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end else begin
                // bounce back restarts the count
                cnt <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/rx_store.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_consts.svh"

module rx_store (
    input  logic                   clk,
    input  logic                   reset,
    input  uart_pkg::byte_strobe_t rx_byte,
    input  uart_pkg::buf_addr_t    rd_addr,
    output uart_pkg::uart_byte_t   rd_data,
    output uart_pkg::buf_len_t     fill_len
);

    localparam uart_pkg::buf_len_t DEPTH_LEN = uart_pkg::buf_len_t'(`UART_BUF_DEPTH);

    uart_pkg::uart_byte_t mem [0:`UART_BUF_DEPTH-1];
    logic                 wr_en;

    // bytes past a full buffer are lost
    assign wr_en = rx_byte.valid && (fill_len < DEPTH_LEN);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fill_len <= '0;
        end else if (wr_en) begin
            fill_len <= fill_len + 1'b1;
        end
    end

    // write slot is the current fill count
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[uart_pkg::buf_addr_t'(fill_len)] <= rx_byte.data;
        end
    end

    // async read for the sequencer
    assign rd_data = mem[rd_addr];

    a_fill_bound : assert property (
        @(posedge clk) disable iff (reset) fill_len <= DEPTH_LEN
    );

endmodule

`default_nettype wire

//--- rtl/echo_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module echo_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   send_pulse,
    input  uart_pkg::buf_len_t     fill_len,
    input  uart_pkg::uart_byte_t   rd_data,
    input  logic                   tx_done,
    output uart_pkg::buf_addr_t    rd_addr,
    output uart_pkg::byte_strobe_t tx_req
);

    typedef enum logic {
        SEQ_IDLE,
        SEQ_REPLAY
    } seq_state_t;

    seq_state_t           state;
    uart_pkg::buf_addr_t  idx;
    uart_pkg::buf_len_t   len_q;
    uart_pkg::buf_len_t   next_count;
    logic                 start;
    logic                 advance;
    logic                 req_valid;
    uart_pkg::uart_byte_t req_data;

    // bytes sent once idx advances
    assign next_count = uart_pkg::buf_len_t'(idx) + 1'b1;

    assign start   = (state == SEQ_IDLE) && send_pulse && (fill_len != '0);
    assign advance = (state == SEQ_REPLAY) && tx_done && (next_count < len_q);

    // address the byte to load next
    assign rd_addr = (state == SEQ_IDLE) ? '0 : idx + 1'b1;

    // ======================================================================
    // replay FSM
    // ======================================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= SEQ_IDLE;
            idx       <= '0;
            len_q     <= '0;
            req_valid <= 1'b0;
        end else begin
            req_valid <= start || advance;
            if (start) begin
                // length frozen here, later bytes wait for the next press
                state <= SEQ_REPLAY;
                idx   <= '0;
                len_q <= fill_len;
            end else if (advance) begin
                idx <= idx + 1'b1;
            end else if (state == SEQ_REPLAY && tx_done) begin
                // last byte done
                state <= SEQ_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || advance) begin
            req_data <= rd_data;
        end
    end

    // one strobe per byte, data held until the next load
    assign tx_req = '{valid: req_valid, data: req_data};

    a_req_timing : assert property (
        @(posedge clk) disable iff (reset)
        tx_req.valid |-> ($past(send_pulse) || $past(tx_done))
    );

endmodule

`default_nettype wire

//--- rtl/uart_echo_top.sv
`timescale 1ns/1ns
`default_nettype none

module uart_echo_top (
    input  logic clk,
    input  logic reset,
    input  logic rxd,
    input  logic send_btn,
    output logic txd
);

    uart_pkg::byte_strobe_t rx_byte;
    uart_pkg::byte_strobe_t tx_req;
    uart_pkg::buf_addr_t    rd_addr;
    uart_pkg::uart_byte_t   rd_data;
    uart_pkg::buf_len_t     fill_len;
    logic                   send_pulse;
    logic                   tx_done;

    // ======================================================================
    // receive path
    // ======================================================================
    uart_rx u_uart_rx (
        .clk     (clk),
        .reset   (reset),
        .rxd     (rxd),
        .rx_byte (rx_byte)
    );

    rx_store u_rx_store (
        .clk      (clk),
        .reset    (reset),
        .rx_byte  (rx_byte),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .fill_len (fill_len)
    );

    // ======================================================================
    // replay path
    // ======================================================================
    button_debounce u_button_debounce (
        .clk   (clk),
        .reset (reset),
        .btn   (send_btn),
        .pulse (send_pulse)
    );

    echo_sequencer u_echo_sequencer (
        .clk        (clk),
        .reset      (reset),
        .send_pulse (send_pulse),
        .fill_len   (fill_len),
        .rd_data    (rd_data),
        .tx_done    (tx_done),
        .rd_addr    (rd_addr),
        .tx_req     (tx_req)
    );

    // busy only feeds the transmitter's own check
    uart_tx u_uart_tx (
        .clk     (clk),
        .reset   (reset),
        .tx_req  (tx_req),
        .txd     (txd),
        .tx_done (tx_done),
        .busy    ()
    );

endmodule

`default_nettype wire

//--- test/uart_echo_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_consts.svh"

module uart_echo_tb;

    localparam int BIT_CYCLES    = `UART_CLKS_PER_BIT;
    localparam int IDLE_WINDOW   = 20 * BIT_CYCLES;
    localparam int START_TIMEOUT = 40 * BIT_CYCLES;
    localparam int FULL_PRESS    = `DEBOUNCE_CYCLES + 4;
    localparam int SHORT_PRESS   = `DEBOUNCE_CYCLES - 3;

    logic clk;
    logic reset;
    logic rxd;
    logic send_btn;
    logic txd;

    // bytes the DUT should hold, oldest first
    uart_pkg::uart_byte_t ref_q[$];

    uart_echo_top u_uart_echo_top (
        .clk      (clk),
        .reset    (reset),
        .rxd      (rxd),
        .send_btn (send_btn),
        .txd      (txd)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // ======================================================================
    // failure handling and compare
    // ======================================================================
    task automatic end_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    // ======================================================================
    // stimulus
    // ======================================================================
    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        // DUT buffer is empty again
        ref_q.delete();
        repeat (2) @(posedge clk);
    endtask

    // one frame on rxd, lsb first
    task automatic send_frame(input uart_pkg::uart_byte_t data);
        int i;
        @(posedge clk);
        rxd <= 1'b0;
        repeat (BIT_CYCLES) @(posedge clk);
        for (i = 0; i < `UART_DATA_BITS; i++) begin
            rxd <= data[i];
            repeat (BIT_CYCLES) @(posedge clk);
        end
        rxd <= 1'b1;
        repeat (BIT_CYCLES) @(posedge clk);
        // bytes past a full buffer are dropped by the DUT too
        if (ref_q.size() < `UART_BUF_DEPTH) begin
            ref_q.push_back(data);
        end
    endtask

    task automatic send_random_bytes(input int count);
        int i;
        for (i = 0; i < count; i++) begin
            send_frame(uart_pkg::uart_byte_t'($urandom()));
        end
    endtask

    task automatic press_button(input int hold_cycles);
        @(posedge clk);
        send_btn <= 1'b1;
        repeat (hold_cycles) @(posedge clk);
        send_btn <= 1'b0;
    endtask

    // ======================================================================
    // txd monitor, sampled on the falling edge
    // ======================================================================
    task automatic receive_frame(output uart_pkg::uart_byte_t data);
        int waited;
        int i;
        uart_pkg::uart_byte_t shift;
        waited = 0;
        @(negedge clk);
        while (txd !== 1'b0) begin
            if (waited >= START_TIMEOUT) begin
                $display("ERROR: no start bit on txd within %0d cycles", waited);
                end_with_failure();
            end
            waited++;
            @(negedge clk);
        end
        // half a bit to the middle of the start bit
        repeat (BIT_CYCLES / 2) @(negedge clk);
        if (txd !== 1'b0) begin
            $display("ERROR: start bit on txd did not stay low at %0t ns", $time);
            end_with_failure();
        end
        for (i = 0; i < `UART_DATA_BITS; i++) begin
            repeat (BIT_CYCLES) @(negedge clk);
            shift[i] = txd;
        end
        repeat (BIT_CYCLES) @(negedge clk);
        if (txd !== 1'b1) begin
            $display("ERROR: stop bit on txd was low at %0t ns", $time);
            end_with_failure();
        end
        data = shift;
    endtask

    task automatic receive_and_compare(input int count);
        int i;
        uart_pkg::uart_byte_t got;
        for (i = 0; i < count; i++) begin
            receive_frame(got);
            check_value(32'(got), 32'(ref_q[i]), $sformatf("replay byte %0d", i));
        end
    endtask

    // txd must hold high for the whole window
    task automatic expect_idle(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_value(32'(txd), 32'd1, "txd idle");
        end
    endtask

    // ======================================================================
    // directed tests
    // ======================================================================
    task automatic test_empty_press();
        apply_reset();
        press_button(FULL_PRESS);
        expect_idle(IDLE_WINDOW);
    endtask

    task automatic test_echo();
        send_random_bytes(5);
        fork
            press_button(FULL_PRESS);
            receive_and_compare(5);
        join
    endtask

    // replay leaves the buffer as it was
    task automatic test_repeat_replay();
        fork
            press_button(FULL_PRESS);
            receive_and_compare(ref_q.size());
        join
        expect_idle(IDLE_WINDOW);
    endtask

    task automatic test_glitch();
        press_button(SHORT_PRESS);
        expect_idle(IDLE_WINDOW);
        fork
            press_button(FULL_PRESS);
            receive_and_compare(ref_q.size());
        join
    endtask

    task automatic test_busy_press();
        apply_reset();
        send_random_bytes(4);
        fork
            begin
                press_button(FULL_PRESS);
                // second press lands in the middle of the replay
                repeat (12 * BIT_CYCLES) @(posedge clk);
                press_button(FULL_PRESS);
            end
            receive_and_compare(4);
        join
        expect_idle(IDLE_WINDOW);
    endtask

    task automatic test_overflow();
        apply_reset();
        send_random_bytes(`UART_BUF_DEPTH + 2);
        fork
            press_button(FULL_PRESS);
            receive_and_compare(`UART_BUF_DEPTH);
        join
        expect_idle(IDLE_WINDOW);
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        rxd      = 1'b1;
        send_btn = 1'b0;
        void'($urandom(32'he184));

        test_empty_press();
        $display("empty press done at %0t ns", $time);
        test_echo();
        $display("echo done at %0t ns", $time);
        test_repeat_replay();
        $display("repeat replay done at %0t ns", $time);
        test_glitch();
        $display("glitch rejection done at %0t ns", $time);
        test_busy_press();
        $display("busy press done at %0t ns", $time);
        test_overflow();
        $display("overflow done at %0t ns", $time);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+rtl
rtl/uart_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/button_debounce.sv
rtl/rx_store.sv
rtl/echo_sequencer.sv
rtl/uart_echo_top.sv
test/uart_echo_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the UART echo testbench with Verilator and run it.
# The exit status is nonzero when the build fails or the testbench fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f sim.f \
    --top-module uart_echo_tb \
    -o uart_echo_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/uart_echo_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
